//--- common/vram_bank_if.sv
// one bank's access port: select, masked write data and registered read data
interface vram_bank_if #(
    parameter int DEPTH_W = 14
);

    logic               sel;        // access this bank this cycle
    logic               wr_en;
    vram_pkg::mask_t    wr_mask;    // one bit per nibble
    logic [DEPTH_W-1:0] addr;       // in-bank word address
    vram_pkg::word_t    wdata;
    vram_pkg::word_t    rdata;      // valid the cycle after sel

    // arbiter side
    modport ctrl (output sel, wr_en, wr_mask, addr, wdata);

    // ram side
    modport mem (input sel, wr_en, wr_mask, addr, wdata, output rdata);

    // read return only looks at data
    modport mon (input rdata);

endinterface

//--- common/vram_pkg.sv
// video memory shared types: word and mask widths, access owner encoding
package vram_pkg;

    localparam int WORD_W   = 16;               // bits per memory word
    localparam int MASK_W   = 4;                // one write enable per nibble
    localparam int NIBBLE_W = WORD_W / MASK_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [MASK_W-1:0] mask_t;

    // who owns the access sitting on the bank interfaces
    typedef enum logic [1:0] {
        ACC_NONE    = 2'd0,     // idle cycle
        ACC_HOST_RD = 2'd1,
        ACC_HOST_WR = 2'd2,     // no read return
        ACC_DISP    = 2'd3      // raster fetch
    } access_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the vram testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module vram_tb \
    -f sim.f \
    --Mdir obj_dir \
    -o vram_sim

./obj_dir/vram_sim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

//--- sim.f
common/vram_pkg.sv
common/vram_bank_if.sv
vram/vram_bank.sv
vram/vram_arbiter.sv
vram/vram_read_mux.sv
verilog/vram_top.sv
sim/vram_tb.sv

//--- sim/vram_tb.sv
// video memory testbench with reference model, timed read checks, collisions and random traffic
module vram_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W          = 16;
    localparam int BANK_COUNT      = 4;
    localparam int BANK_W          = $clog2(BANK_COUNT);
    localparam int DEPTH_W         = ADDR_W - BANK_W;
    localparam int NIB_W           = vram_pkg::WORD_W / vram_pkg::MASK_W;
    localparam int CLK_PERIOD      = 40;
    localparam int RST_CYCLES      = 5;
    localparam int POOL_SIZE       = 16;   // addresses that get written first
    localparam int DIRECTED_CYCLES = 240;
    localparam int RAND_CYCLES     = 400;
    localparam int MARGIN_CYCLES   = 100;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + MARGIN_CYCLES;

    logic              clk        = 1'b0;
    logic              rst        = 1'b1;
    logic              host_req   = 1'b0;
    logic              host_wr    = 1'b0;
    logic [ADDR_W-1:0] host_addr  = '0;
    vram_pkg::mask_t   host_mask  = '0;
    vram_pkg::word_t   host_wdata = '0;
    logic              disp_req   = 1'b0;
    logic [ADDR_W-1:0] disp_addr  = '0;
    logic              host_rd_valid;
    vram_pkg::word_t   host_rd_data;
    logic              disp_valid;
    vram_pkg::word_t   disp_data;

    int seed        = 32'h97e0_bfc7;
    int cyc         = 0;                 // cycle number counted at each rising edge
    int errors      = 0;
    int host_checks = 0;
    int disp_checks = 0;
    int last_host   = -10;               // cycle of the latest strobe per port
    int last_disp   = -10;

    vram_pkg::word_t   ref_mem [0:2**ADDR_W-1];
    logic [ADDR_W-1:0] pool [$];

    // expected responses per port with the cycle each is due
    int                host_due_q [$];
    vram_pkg::word_t   host_data_q [$];
    int                disp_due_q [$];
    vram_pkg::word_t   disp_data_q [$];

    vram_top #(
        .ADDR_W     (ADDR_W),
        .BANK_COUNT (BANK_COUNT)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .host_req      (host_req),
        .host_wr       (host_wr),
        .host_addr     (host_addr),
        .host_mask     (host_mask),
        .host_wdata    (host_wdata),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data),
        .disp_req      (disp_req),
        .disp_addr     (disp_addr),
        .disp_valid    (disp_valid),
        .disp_data     (disp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // nibble n is bits 4n+3..4n and is kept from old_word unless its mask bit is set
    function automatic vram_pkg::word_t merge_nibbles(input vram_pkg::word_t old_word,
                                                      input vram_pkg::word_t new_word,
                                                      input vram_pkg::mask_t mask);
        vram_pkg::word_t result;
        result = old_word;
        for (int n = 0; n < vram_pkg::MASK_W; n++) begin
            if (mask[n]) result[n*NIB_W +: NIB_W] = new_word[n*NIB_W +: NIB_W];
        end
        return result;
    endfunction

    // one clock of stimulus with the model taking display before host as the arbiter does
    task automatic issue(input logic hr, input logic hw, input logic [ADDR_W-1:0] ha,
                         input vram_pkg::mask_t hm, input vram_pkg::word_t hd,
                         input logic dr, input logic [ADDR_W-1:0] da);
        @(posedge clk);
        cyc = cyc + 1;
        host_req   <= hr;
        host_wr    <= hw;
        host_addr  <= ha;
        host_mask  <= hm;
        host_wdata <= hd;
        disp_req   <= dr;
        disp_addr  <= da;
        if (dr) begin
            disp_due_q.push_back(cyc + 3);
            disp_data_q.push_back(ref_mem[da]);
            last_disp = cyc;
        end
        if (hr) begin
            last_host = cyc;
            if (hw) begin
                ref_mem[ha] = merge_nibbles(ref_mem[ha], hd, hm);
            end else begin
                host_due_q.push_back(dr ? cyc + 4 : cyc + 3);   // one extra when parked
                host_data_q.push_back(ref_mem[ha]);
            end
        end
    endtask

    // both ports strobe while rst is high and nothing may come back
    task automatic strobe_in_reset(input logic both);
        @(posedge clk);
        cyc = cyc + 1;
        host_req  <= both;
        host_wr   <= 1'b0;
        host_addr <= ADDR_W'($random(seed));
        disp_req  <= both;
        disp_addr <= ADDR_W'($random(seed));
    endtask

    task automatic idle_cycle();
        issue(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    // directed accesses leave a gap so each port strobes every other cycle
    task automatic host_write(input logic [ADDR_W-1:0] addr, input vram_pkg::mask_t mask,
                              input vram_pkg::word_t data);
        issue(1'b1, 1'b1, addr, mask, data, 1'b0, '0);
        idle_cycle();
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr);
        issue(1'b1, 1'b0, addr, '0, '0, 1'b0, '0);
        idle_cycle();
    endtask

    task automatic disp_fetch(input logic [ADDR_W-1:0] addr);
        issue(1'b0, 1'b0, '0, '0, '0, 1'b1, addr);
        idle_cycle();
    endtask

    task automatic strobe_both(input logic hw, input logic [ADDR_W-1:0] ha,
                               input vram_pkg::mask_t hm, input vram_pkg::word_t hd,
                               input logic [ADDR_W-1:0] da);
        issue(1'b1, hw, ha, hm, hd, 1'b1, da);
        idle_cycle();
    endtask

    task automatic build_pool();
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool.push_back({BANK_W'(i % BANK_COUNT), DEPTH_W'($random(seed))});  // every bank
        end
    endtask

    task automatic write_all_banks();
        for (int i = 0; i < POOL_SIZE; i++) begin
            host_write(pool[i], 4'hf, vram_pkg::word_t'($random(seed)));
        end
        for (int i = 0; i < POOL_SIZE; i++) begin
            host_read(pool[i]);
        end
    endtask

    task automatic merge_partial();
        for (int i = 0; i < POOL_SIZE; i++) begin
            host_write(pool[i], vram_pkg::mask_t'(i * 5 + 1), vram_pkg::word_t'($random(seed)));
        end
        for (int i = 0; i < POOL_SIZE; i++) begin
            host_read(pool[i]);
        end
    endtask

    task automatic fetch_for_raster();
        for (int i = 0; i < POOL_SIZE; i++) begin
            disp_fetch(pool[i]);
        end
        // ports on alternate cycles so reads overlap in the pipe
        for (int i = 0; i < POOL_SIZE; i++) begin
            issue(1'b1, 1'b0, pool[i], '0, '0, 1'b0, '0);
            issue(1'b0, 1'b0, '0, '0, '0, 1'b1, pool[POOL_SIZE-1-i]);
        end
        idle_cycle();
    endtask

    task automatic collide_ports();
        strobe_both(1'b0, pool[5], '0, '0, pool[0]);
        strobe_both(1'b0, pool[6], '0, '0, pool[6]);
        strobe_both(1'b1, pool[2], 4'hf, 16'h5a3c, pool[2]);    // display still gets old word
        host_read(pool[2]);
        strobe_both(1'b1, pool[7], 4'b0110, 16'hc7e1, pool[3]);
        disp_fetch(pool[7]);
        strobe_both(1'b1, pool[8], 4'b1001, 16'h2b4d, pool[8]);
        strobe_both(1'b0, pool[8], '0, '0, pool[8]);            // back to back collisions
    endtask

    task automatic read_after_write();
        host_write(pool[9], 4'hf, 16'h9e17);
        host_read(pool[9]);
        host_write(pool[10], 4'b0011, 16'h3f80);
        disp_fetch(pool[10]);
        host_write(pool[11], 4'b1100, 16'h71c2);
        issue(1'b1, 1'b0, pool[11], '0, '0, 1'b1, pool[11]);
        idle_cycle();
    endtask

    task automatic random_traffic(input int n);
        logic              hr;
        logic              hw;
        logic              dr;
        vram_pkg::mask_t   hm;
        vram_pkg::word_t   hd;
        logic [ADDR_W-1:0] ha;
        logic [ADDR_W-1:0] da;
        for (int i = 0; i < n; i++) begin
            hr = (cyc + 1 - last_host >= 2) && (($random(seed) & 3) != 0);
            dr = (cyc + 1 - last_disp >= 2) && (($random(seed) & 3) != 0);
            hw = ($random(seed) & 1) != 0;
            hm = vram_pkg::mask_t'($random(seed));
            hd = vram_pkg::word_t'($random(seed));
            ha = pool[($random(seed) & 32'h7fff_ffff) % POOL_SIZE];
            da = pool[($random(seed) & 32'h7fff_ffff) % POOL_SIZE];
            issue(hr, hw, ha, hm, hd, dr, da);
        end
    endtask

    // no read data may come out while reset is on or just after
    quiet_in_reset: assert property (@(negedge clk)
        (cyc >= 1 && cyc <= RST_CYCLES + 1) |-> (!host_rd_valid && !disp_valid))
    else begin
        errors++;
        $display("read valid raised during reset or the cycle after it, t=%0t", $time);
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        int              due;
        vram_pkg::word_t exp_word;
        if (host_rd_valid === 1'b1) begin
            assert (host_due_q.size() != 0 && host_due_q[0] == cyc) else begin
                errors++;
                $display("host_rd_valid in cycle %0d with no host read due, t=%0t", cyc, $time);
            end
            if (host_due_q.size() != 0 && host_due_q[0] == cyc) begin
                due = host_due_q.pop_front();
                exp_word = host_data_q.pop_front();
                host_checks++;
                assert (host_rd_data === exp_word) else begin
                    errors++;
                    $display("Fail t=%0t host_rd_data expected %h got %h",
                             $time, exp_word, host_rd_data);
                end
            end
        end else begin
            assert (host_due_q.size() == 0 || host_due_q[0] > cyc) else begin
                due = host_due_q.pop_front();
                exp_word = host_data_q.pop_front();
                errors++;
                $display("host read due in cycle %0d never got host_rd_valid, t=%0t", due, $time);
            end
        end
        if (disp_valid === 1'b1) begin
            assert (disp_due_q.size() != 0 && disp_due_q[0] == cyc) else begin
                errors++;
                $display("disp_valid in cycle %0d with no fetch due, t=%0t", cyc, $time);
            end
            if (disp_due_q.size() != 0 && disp_due_q[0] == cyc) begin
                due = disp_due_q.pop_front();
                exp_word = disp_data_q.pop_front();
                disp_checks++;
                assert (disp_data === exp_word) else begin
                    errors++;
                    $display("Fail t=%0t disp_data expected %h got %h", $time, exp_word, disp_data);
                end
            end
        end else begin
            assert (disp_due_q.size() == 0 || disp_due_q[0] > cyc) else begin
                due = disp_due_q.pop_front();
                exp_word = disp_data_q.pop_front();
                errors++;
                $display("display fetch due in cycle %0d never got disp_valid, t=%0t", due, $time);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, responses still missing", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < RST_CYCLES; i++) begin
            strobe_in_reset(i < RST_CYCLES - 1 && i % 2 == 0);   // colliding strobes to drop
        end
        rst <= 1'b0;
        repeat (3) idle_cycle();
        build_pool();
        write_all_banks();
        merge_partial();
        fetch_for_raster();
        collide_ports();
        read_after_write();
        random_traffic(RAND_CYCLES);
        while (host_due_q.size() != 0 || disp_due_q.size() != 0) idle_cycle();
        repeat (4) idle_cycle();   // catch late strays
        $display("host reads checked %0d, display reads checked %0d, errors %0d",
                 host_checks, disp_checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/vram_top.sv
// video memory top: host and display ports onto four banks through arbiter and read return
module vram_top #(
    parameter int ADDR_W     = 16,
    parameter int BANK_COUNT = 4
) (
    input  logic              clk,
    input  logic              rst,

    // host port, reads and nibble-masked writes
    input  logic              host_req,
    input  logic              host_wr,
    input  logic [ADDR_W-1:0] host_addr,
    input  vram_pkg::mask_t   host_mask,
    input  vram_pkg::word_t   host_wdata,
    output logic              host_rd_valid,
    output vram_pkg::word_t   host_rd_data,

    // display fetch port
    input  logic              disp_req,
    input  logic [ADDR_W-1:0] disp_addr,
    output logic              disp_valid,
    output vram_pkg::word_t   disp_data
);

    localparam int BANK_W  = $clog2(BANK_COUNT);
    localparam int DEPTH_W = ADDR_W - BANK_W;   // words per bank, as address bits

    vram_pkg::access_e issue_owner;
    logic [BANK_W-1:0] issue_bank;

    vram_bank_if #(.DEPTH_W(DEPTH_W)) bank_bus [0:BANK_COUNT-1] ();

    vram_arbiter #(
        .ADDR_W     (ADDR_W),
        .BANK_COUNT (BANK_COUNT)
    ) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_wr     (host_wr),
        .host_addr   (host_addr),
        .host_mask   (host_mask),
        .host_wdata  (host_wdata),
        .disp_req    (disp_req),
        .disp_addr   (disp_addr),
        .banks       (bank_bus),
        .issue_owner (issue_owner),
        .issue_bank  (issue_bank)
    );

    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
        vram_bank #(
            .DEPTH_W (DEPTH_W)
        ) u_bank (
            .clk (clk),
            .bus (bank_bus[g])
        );
    end

    // one stage behind the arbiter, one more for the output register
    vram_read_mux #(
        .BANK_COUNT (BANK_COUNT)
    ) u_read_mux (
        .clk           (clk),
        .rst           (rst),
        .issue_owner   (issue_owner),
        .issue_bank    (issue_bank),
        .banks         (bank_bus),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data),
        .disp_valid    (disp_valid),
        .disp_data     (disp_data)
    );

endmodule

//--- vram/vram_arbiter.sv
// vram arbiter: registers one access per cycle, display first, colliding host access parked once
module vram_arbiter #(
    parameter int ADDR_W     = 16,
    parameter int BANK_COUNT = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          host_req,
    input  logic                          host_wr,
    input  logic [ADDR_W-1:0]             host_addr,
    input  vram_pkg::mask_t               host_mask,
    input  vram_pkg::word_t               host_wdata,
    input  logic                          disp_req,
    input  logic [ADDR_W-1:0]             disp_addr,
    vram_bank_if.ctrl                     banks [0:BANK_COUNT-1],
    output vram_pkg::access_e             issue_owner,
    output logic [$clog2(BANK_COUNT)-1:0] issue_bank
);

    localparam int BANK_W  = $clog2(BANK_COUNT);
    localparam int DEPTH_W = ADDR_W - BANK_W;

    // host access that lost to the display
    logic              hold_valid;
    logic              hold_wr;
    logic [ADDR_W-1:0] hold_addr;
    vram_pkg::mask_t   hold_mask;
    vram_pkg::word_t   hold_wdata;

    // winner of this cycle
    vram_pkg::access_e next_owner;
    logic [ADDR_W-1:0] next_addr;
    vram_pkg::mask_t   next_mask;
    vram_pkg::word_t   next_wdata;
    logic              park;

    // access on the bank interfaces
    vram_pkg::access_e iss_owner;
    logic [ADDR_W-1:0] iss_addr;
    vram_pkg::mask_t   iss_mask;
    vram_pkg::word_t   iss_wdata;
    logic              iss_write;
    logic [BANK_COUNT-1:0] bank_hit;

    // display beats the slot, the slot beats a fresh host strobe
    always_comb begin
        next_owner = vram_pkg::ACC_NONE;
        next_addr  = host_addr;
        next_mask  = host_mask;
        next_wdata = host_wdata;
        if (disp_req) begin
            next_owner = vram_pkg::ACC_DISP;
            next_addr  = disp_addr;
        end else if (hold_valid) begin
            if (hold_wr) next_owner = vram_pkg::ACC_HOST_WR;
            else next_owner = vram_pkg::ACC_HOST_RD;
            next_addr  = hold_addr;
            next_mask  = hold_mask;
            next_wdata = hold_wdata;
        end else if (host_req) begin
            if (host_wr) next_owner = vram_pkg::ACC_HOST_WR;
            else next_owner = vram_pkg::ACC_HOST_RD;
        end
    end

    assign park = host_req && (disp_req || hold_valid);     // host strobe did not win

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            iss_owner  <= vram_pkg::ACC_NONE;
        end else begin
            hold_valid <= park;
            iss_owner  <= next_owner;
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            hold_wr    <= host_wr;
            hold_addr  <= host_addr;
            hold_mask  <= host_mask;
            hold_wdata <= host_wdata;
        end
        iss_addr  <= next_addr;
        iss_mask  <= next_mask;
        iss_wdata <= next_wdata;
    end

    assign iss_write   = (iss_owner == vram_pkg::ACC_HOST_WR);
    assign issue_owner = iss_owner;
    assign issue_bank  = iss_addr[ADDR_W-1 -: BANK_W];     // bank = top address bits

    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank_drive
        assign bank_hit[g]    = (iss_owner != vram_pkg::ACC_NONE) &&
                                (issue_bank == BANK_W'(g));
        assign banks[g].sel     = bank_hit[g];
        assign banks[g].wr_en   = bank_hit[g] && iss_write;
        assign banks[g].wr_mask = iss_write ? iss_mask : '0;    // reads never merge
        assign banks[g].addr    = iss_addr[DEPTH_W-1:0];
        assign banks[g].wdata   = iss_wdata;
    end

endmodule

//--- vram/vram_bank.sv
// vram bank: synchronous word ram with nibble-masked write and registered read
module vram_bank #(
    parameter int DEPTH_W = 14
) (
    input  logic    clk,
    vram_bank_if.mem bus
);

    localparam int DEPTH = 2 ** DEPTH_W;

    vram_pkg::word_t mem [0:DEPTH-1];   // contents undefined until written

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (bus.sel) begin
            if (bus.wr_en) begin
                for (int n = 0; n < vram_pkg::MASK_W; n++) begin
                    if (bus.wr_mask[n]) begin
                        mem[bus.addr][n*vram_pkg::NIBBLE_W +: vram_pkg::NIBBLE_W] <=
                            bus.wdata[n*vram_pkg::NIBBLE_W +: vram_pkg::NIBBLE_W];
                    end
                end
            end
            bus.rdata <= mem[bus.addr];
        end
    end

endmodule

//--- vram/vram_read_mux.sv
// vram read return: follows each access one stage behind and steers bank data to its owner
module vram_read_mux #(
    parameter int BANK_COUNT = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  vram_pkg::access_e             issue_owner,
    input  logic [$clog2(BANK_COUNT)-1:0] issue_bank,
    vram_bank_if.mon                      banks [0:BANK_COUNT-1],
    output logic                          host_rd_valid,
    output vram_pkg::word_t               host_rd_data,
    output logic                          disp_valid,
    output vram_pkg::word_t               disp_data
);

    localparam int BANK_W = $clog2(BANK_COUNT);

    vram_pkg::access_e rd_owner;        // owner of the word now on rdata
    logic [BANK_W-1:0] rd_bank;
    vram_pkg::word_t   bank_rdata [0:BANK_COUNT-1];
    vram_pkg::word_t   rd_word;

    // flatten so the bank can be picked at run time
    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_rdata
        assign bank_rdata[g] = banks[g].rdata;
    end

    assign rd_word = bank_rdata[rd_bank];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_owner      <= vram_pkg::ACC_NONE;
            host_rd_valid <= 1'b0;
            disp_valid    <= 1'b0;
        end else begin
            rd_owner      <= issue_owner;
            host_rd_valid <= (rd_owner == vram_pkg::ACC_HOST_RD);
            disp_valid    <= (rd_owner == vram_pkg::ACC_DISP);  // writes and idle give nothing
        end
    end

    always_ff @(posedge clk) begin
        rd_bank <= issue_bank;
        if (rd_owner == vram_pkg::ACC_HOST_RD) host_rd_data <= rd_word;
        if (rd_owner == vram_pkg::ACC_DISP) disp_data <= rd_word;
    end

endmodule
